//--- src/rvcore_consts.svh
// width, opcode, reset pc and register count macros for the rv32i core
`ifndef RVCORE_CONSTS_SVH
`define RVCORE_CONSTS_SVH

// datapath sizes
`define CPU_WIDTH       32
`define REG_ADDR_WIDTH  5
`define REG_NUM         32
`define OPC_WIDTH       7
`define SHAMT_WIDTH     5

// first fetch address after reset
`define RESET_PC        32'h8000_0000

// major opcodes, inst[6:0]
`define OPC_OP          7'b0110011 // register alu ops
`define OPC_OP_IMM      7'b0010011 // immediate alu ops
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_SYSTEM      7'b1110011

// funct7 values that select sub and sra
`define FUNCT7_BASE     7'b0000000
`define FUNCT7_ALT      7'b0100000

// the only system instruction the core accepts
`define INST_EBREAK     32'h0010_0073

`endif

//--- src/rvcore_pkg.sv
// shared word, register address and opcode types plus the control enums
`include "rvcore_consts.svh"

package rvcore_pkg;

    typedef logic [`CPU_WIDTH-1:0]      word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`OPC_WIDTH-1:0]      opcode_t;

    // alu function select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE
    } imm_kind_e;

    typedef enum logic [1:0] {
        SRC1_REG,
        SRC1_PC,
        SRC1_ZERO
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_REG,
        SRC2_IMM,
        SRC2_FOUR
    } src2_sel_e;

    // encodings match the branch funct3 field
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

endpackage

//--- src/pc_unit.sv
// program counter register, halt flag and next-pc selection
`timescale 1ns/100ps
`include "rvcore_consts.svh"

module pc_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              branch,      // conditional branch decoded
    input  logic              jump,        // jal or jalr
    input  logic              jalr,
    input  logic              ebreak_flag,
    input  logic              br_taken,    // compare result from alu
    input  rvcore_pkg::word_t imm,
    input  rvcore_pkg::word_t reg1_rdata,  // jalr base
    output rvcore_pkg::word_t pc,
    output logic              halted
);

    rvcore_pkg::word_t next_pc;
    rvcore_pkg::word_t jalr_target;

    assign jalr_target = reg1_rdata + imm;

    // priority is halt, jalr, pc relative, then sequential
    always_comb begin
        if (ebreak_flag) begin
            next_pc = pc; // stay on the ebreak
        end else if (jalr) begin
            next_pc = {jalr_target[`CPU_WIDTH-1:1], 1'b0};
        end else if (jump || (branch && br_taken)) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + rvcore_pkg::word_t'(4);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            pc <= next_pc;
            if (ebreak_flag) begin
                halted <= 1'b1; // sticky until reset
            end
        end
    end

endmodule

//--- src/decoder.sv
// instruction decode into register addresses and datapath control
`timescale 1ns/100ps
`include "rvcore_consts.svh"

module decoder (
    input  rvcore_pkg::word_t     inst,
    input  logic                  halted,
    output rvcore_pkg::reg_addr_t reg1_raddr,
    output rvcore_pkg::reg_addr_t reg2_raddr,
    output rvcore_pkg::reg_addr_t reg_waddr,
    output logic                  reg_wen,
    output rvcore_pkg::imm_kind_e imm_kind,
    output rvcore_pkg::alu_op_e   alu_op,
    output rvcore_pkg::src1_sel_e src1_sel,
    output rvcore_pkg::src2_sel_e src2_sel,
    output rvcore_pkg::br_cond_e  br_cond,
    output logic                  branch,
    output logic                  jump,
    output logic                  jalr,
    output logic                  ebreak_flag,
    output logic                  unknown_code
);

    rvcore_pkg::opcode_t opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                legal;
    logic                wen_dec;  // write enable before legality and halt
    logic                br_dec;
    logic                jump_dec;
    logic                jalr_dec;

    // funct3 to alu op, alt picks sub or sra
    function automatic rvcore_pkg::alu_op_e funct3_to_alu(input logic [2:0] f3,
                                                          input logic alt);
        case (f3)
            3'b000:  funct3_to_alu = alt ? rvcore_pkg::ALU_SUB : rvcore_pkg::ALU_ADD;
            3'b001:  funct3_to_alu = rvcore_pkg::ALU_SLL;
            3'b010:  funct3_to_alu = rvcore_pkg::ALU_SLT;
            3'b011:  funct3_to_alu = rvcore_pkg::ALU_SLTU;
            3'b100:  funct3_to_alu = rvcore_pkg::ALU_XOR;
            3'b101:  funct3_to_alu = alt ? rvcore_pkg::ALU_SRA : rvcore_pkg::ALU_SRL;
            3'b110:  funct3_to_alu = rvcore_pkg::ALU_OR;
            default: funct3_to_alu = rvcore_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // register fields are fixed in every format
    assign reg1_raddr = inst[19:15];
    assign reg2_raddr = inst[24:20];
    assign reg_waddr  = inst[11:7];

    always_comb begin
        legal       = 1'b1;
        wen_dec     = 1'b0;
        br_dec      = 1'b0;
        jump_dec    = 1'b0;
        jalr_dec    = 1'b0;
        ebreak_flag = 1'b0;
        imm_kind    = rvcore_pkg::IMM_NONE;
        alu_op      = rvcore_pkg::ALU_PASS_B;
        src1_sel    = rvcore_pkg::SRC1_REG;
        src2_sel    = rvcore_pkg::SRC2_REG;
        br_cond     = rvcore_pkg::BR_EQ;
        case (opcode)
            `OPC_OP: begin
                wen_dec = 1'b1;
                alu_op  = funct3_to_alu(funct3, funct7[5]);
                // alternate funct7 only for sub and sra
                legal   = (funct7 == `FUNCT7_BASE) ||
                          (funct7 == `FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            `OPC_OP_IMM: begin
                wen_dec  = 1'b1;
                imm_kind = rvcore_pkg::IMM_I;
                src2_sel = rvcore_pkg::SRC2_IMM;
                alu_op   = funct3_to_alu(funct3, (funct3 == 3'b101) && funct7[5]);
                if (funct3 == 3'b001) begin
                    legal = (funct7 == `FUNCT7_BASE);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == `FUNCT7_BASE) || (funct7 == `FUNCT7_ALT);
                end
            end
            `OPC_LUI: begin
                wen_dec  = 1'b1;
                imm_kind = rvcore_pkg::IMM_U;
                alu_op   = rvcore_pkg::ALU_ADD;
                src1_sel = rvcore_pkg::SRC1_ZERO;
                src2_sel = rvcore_pkg::SRC2_IMM;
            end
            `OPC_AUIPC: begin
                wen_dec  = 1'b1;
                imm_kind = rvcore_pkg::IMM_U;
                alu_op   = rvcore_pkg::ALU_ADD;
                src1_sel = rvcore_pkg::SRC1_PC;
                src2_sel = rvcore_pkg::SRC2_IMM;
            end
            `OPC_JAL: begin
                wen_dec  = 1'b1;
                jump_dec = 1'b1;
                imm_kind = rvcore_pkg::IMM_J;
                alu_op   = rvcore_pkg::ALU_ADD; // link value pc + 4
                src1_sel = rvcore_pkg::SRC1_PC;
                src2_sel = rvcore_pkg::SRC2_FOUR;
            end
            `OPC_JALR: begin
                wen_dec  = 1'b1;
                jump_dec = 1'b1;
                jalr_dec = 1'b1;
                imm_kind = rvcore_pkg::IMM_I;
                alu_op   = rvcore_pkg::ALU_ADD;
                src1_sel = rvcore_pkg::SRC1_PC;
                src2_sel = rvcore_pkg::SRC2_FOUR;
                legal    = (funct3 == 3'b000);
            end
            `OPC_BRANCH: begin
                br_dec   = 1'b1;
                imm_kind = rvcore_pkg::IMM_B;
                br_cond  = rvcore_pkg::br_cond_e'(funct3);
                legal    = (funct3 != 3'b010) && (funct3 != 3'b011);
            end
            `OPC_SYSTEM: begin
                ebreak_flag = (inst == `INST_EBREAK);
                legal       = (inst == `INST_EBREAK);
            end
            default: legal = 1'b0;
        endcase
    end

    assign unknown_code = !legal;

    // illegal encodings fall through as a plain pc + 4
    assign reg_wen = wen_dec && legal && !halted;
    assign branch  = br_dec && legal;
    assign jump    = jump_dec && legal;
    assign jalr    = jalr_dec && legal;

endmodule

//--- src/imm_gen.sv
// sign-extended immediate builder for the I, S, B, U and J formats
`timescale 1ns/100ps

module imm_gen (
    input  rvcore_pkg::word_t     inst,
    input  rvcore_pkg::imm_kind_e imm_kind,
    output rvcore_pkg::word_t     imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_kind)
            rvcore_pkg::IMM_I: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            rvcore_pkg::IMM_S: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            rvcore_pkg::IMM_B: begin
                // bit 0 always zero for halfword aligned targets
                imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rvcore_pkg::IMM_U: begin
                imm = {inst[31:12], 12'b0};
            end
            rvcore_pkg::IMM_J: begin
                imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0; // register formats
            end
        endcase
    end

endmodule

//--- src/reg_file.sv
// 32 x 32 integer register file with two read ports and one write port
`timescale 1ns/100ps
`include "rvcore_consts.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  reg_wen,
    input  rvcore_pkg::reg_addr_t reg_waddr,
    input  rvcore_pkg::word_t     reg_wdata,
    input  rvcore_pkg::reg_addr_t reg1_raddr,
    input  rvcore_pkg::reg_addr_t reg2_raddr,
    output rvcore_pkg::word_t     reg1_rdata,
    output rvcore_pkg::word_t     reg2_rdata
);

    rvcore_pkg::word_t regs [`REG_NUM];

    // clocked write, x0 never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wen && (reg_waddr != '0)) begin
            regs[reg_waddr] <= reg_wdata;
        end
    end

    // reads see the value before this cycle's write
    assign reg1_rdata = (reg1_raddr == '0) ? '0 : regs[reg1_raddr];
    assign reg2_rdata = (reg2_raddr == '0) ? '0 : regs[reg2_raddr];

endmodule

//--- src/alu.sv
// operand selection, integer alu and branch comparator
`timescale 1ns/100ps
`include "rvcore_consts.svh"

module alu (
    input  rvcore_pkg::alu_op_e   alu_op,
    input  rvcore_pkg::src1_sel_e src1_sel,
    input  rvcore_pkg::src2_sel_e src2_sel,
    input  rvcore_pkg::br_cond_e  br_cond,
    input  rvcore_pkg::word_t     reg1_rdata,
    input  rvcore_pkg::word_t     reg2_rdata,
    input  rvcore_pkg::word_t     pc,
    input  rvcore_pkg::word_t     imm,
    output rvcore_pkg::word_t     alu_res,
    output logic                  br_taken
);

    rvcore_pkg::word_t       src1;
    rvcore_pkg::word_t       src2;
    logic [`SHAMT_WIDTH-1:0] shamt;

    // operand muxes
    always_comb begin
        case (src1_sel)
            rvcore_pkg::SRC1_REG: src1 = reg1_rdata;
            rvcore_pkg::SRC1_PC:  src1 = pc;
            default:              src1 = '0; // lui
        endcase
        case (src2_sel)
            rvcore_pkg::SRC2_REG: src2 = reg2_rdata;
            rvcore_pkg::SRC2_IMM: src2 = imm;
            default:              src2 = rvcore_pkg::word_t'(4); // link offset
        endcase
    end

    assign shamt = src2[`SHAMT_WIDTH-1:0];

    always_comb begin
        case (alu_op)
            rvcore_pkg::ALU_ADD:  alu_res = src1 + src2;
            rvcore_pkg::ALU_SUB:  alu_res = src1 - src2;
            rvcore_pkg::ALU_SLL:  alu_res = src1 << shamt;
            rvcore_pkg::ALU_SLT:  alu_res = rvcore_pkg::word_t'($signed(src1) < $signed(src2));
            rvcore_pkg::ALU_SLTU: alu_res = rvcore_pkg::word_t'(src1 < src2);
            rvcore_pkg::ALU_XOR:  alu_res = src1 ^ src2;
            rvcore_pkg::ALU_SRL:  alu_res = src1 >> shamt;
            rvcore_pkg::ALU_SRA:  alu_res = rvcore_pkg::word_t'($signed(src1) >>> shamt);
            rvcore_pkg::ALU_OR:   alu_res = src1 | src2;
            rvcore_pkg::ALU_AND:  alu_res = src1 & src2;
            default:              alu_res = src2;
        endcase
    end

    // branch compare always on the raw register values
    always_comb begin
        case (br_cond)
            rvcore_pkg::BR_EQ:  br_taken = (reg1_rdata == reg2_rdata);
            rvcore_pkg::BR_NE:  br_taken = (reg1_rdata != reg2_rdata);
            rvcore_pkg::BR_LT:  br_taken = ($signed(reg1_rdata) < $signed(reg2_rdata));
            rvcore_pkg::BR_GE:  br_taken = ($signed(reg1_rdata) >= $signed(reg2_rdata));
            rvcore_pkg::BR_LTU: br_taken = (reg1_rdata < reg2_rdata);
            rvcore_pkg::BR_GEU: br_taken = (reg1_rdata >= reg2_rdata);
            default:            br_taken = 1'b0;
        endcase
    end

endmodule

//--- src/rv_core_top.sv
// single-cycle rv32i core top connecting pc, decode, immediates, registers and alu
`timescale 1ns/100ps

module rv_core_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rvcore_pkg::word_t     inst,         // fetched from pc this cycle
    output rvcore_pkg::word_t     pc,
    output logic                  reg_wen,
    output rvcore_pkg::reg_addr_t reg_waddr,
    output rvcore_pkg::word_t     reg_wdata,
    output logic                  halted,
    output logic                  unknown_code
);

    rvcore_pkg::reg_addr_t reg1_raddr;
    rvcore_pkg::reg_addr_t reg2_raddr;
    rvcore_pkg::word_t     reg1_rdata;
    rvcore_pkg::word_t     reg2_rdata;
    rvcore_pkg::word_t     imm;
    rvcore_pkg::imm_kind_e imm_kind;
    rvcore_pkg::alu_op_e   alu_op;
    rvcore_pkg::src1_sel_e src1_sel;
    rvcore_pkg::src2_sel_e src2_sel;
    rvcore_pkg::br_cond_e  br_cond;
    logic                  branch;
    logic                  jump;
    logic                  jalr;
    logic                  ebreak_flag;
    logic                  br_taken;

    pc_unit u_pc_unit_0 (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .branch       ( branch       ),
        .jump         ( jump         ),
        .jalr         ( jalr         ),
        .ebreak_flag  ( ebreak_flag  ),
        .br_taken     ( br_taken     ),
        .imm          ( imm          ),
        .reg1_rdata   ( reg1_rdata   ),
        .pc           ( pc           ),
        .halted       ( halted       )
    );

    decoder u_decoder_0 (
        .inst         ( inst         ),
        .halted       ( halted       ),
        .reg1_raddr   ( reg1_raddr   ),
        .reg2_raddr   ( reg2_raddr   ),
        .reg_waddr    ( reg_waddr    ),
        .reg_wen      ( reg_wen      ),
        .imm_kind     ( imm_kind     ),
        .alu_op       ( alu_op       ),
        .src1_sel     ( src1_sel     ),
        .src2_sel     ( src2_sel     ),
        .br_cond      ( br_cond      ),
        .branch       ( branch       ),
        .jump         ( jump         ),
        .jalr         ( jalr         ),
        .ebreak_flag  ( ebreak_flag  ),
        .unknown_code ( unknown_code )
    );

    imm_gen u_imm_gen_0 (
        .inst         ( inst         ),
        .imm_kind     ( imm_kind     ),
        .imm          ( imm          )
    );

    reg_file u_reg_file_0 (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .reg_wen      ( reg_wen      ),
        .reg_waddr    ( reg_waddr    ),
        .reg_wdata    ( reg_wdata    ), // alu result is the only writeback source
        .reg1_raddr   ( reg1_raddr   ),
        .reg2_raddr   ( reg2_raddr   ),
        .reg1_rdata   ( reg1_rdata   ),
        .reg2_rdata   ( reg2_rdata   )
    );

    alu u_alu_0 (
        .alu_op       ( alu_op       ),
        .src1_sel     ( src1_sel     ),
        .src2_sel     ( src2_sel     ),
        .br_cond      ( br_cond      ),
        .reg1_rdata   ( reg1_rdata   ),
        .reg2_rdata   ( reg2_rdata   ),
        .pc           ( pc           ),
        .imm          ( imm          ),
        .alu_res      ( reg_wdata    ),
        .br_taken     ( br_taken     )
    );

endmodule

//--- test/tb_rv_core.sv
// testbench for the rv32i core with program memory, reference model and assertion checks
`timescale 1ns/100ps
`include "rvcore_consts.svh"

module tb_rv_core;

    localparam int PROG_LEN   = 64;
    localparam int N_RAND     = 26;
    localparam int MAX_CYCLES = PROG_LEN * 2 + 50;
    localparam rvcore_pkg::word_t MARKER = 32'h0015_0513; // addi x10, x10, 1 (always skipped)

    logic                  clk = 1'b1; // first edge is a falling one
    logic                  rst_n;
    rvcore_pkg::word_t     inst;
    rvcore_pkg::word_t     pc;
    logic                  reg_wen;
    rvcore_pkg::reg_addr_t reg_waddr;
    rvcore_pkg::word_t     reg_wdata;
    logic                  halted;
    logic                  unknown_code;

    rvcore_pkg::word_t     prog [PROG_LEN];
    logic [5:0]            n;          // next free program slot
    int                    cycles;

    // reference model state and its per-cycle expectations
    rvcore_pkg::word_t     m_pc;
    rvcore_pkg::word_t     m_regs [32];
    logic                  m_halted;
    rvcore_pkg::word_t     m_inst;
    rvcore_pkg::word_t     rs1v;
    rvcore_pkg::word_t     rs2v;
    rvcore_pkg::word_t     imm_i;
    rvcore_pkg::word_t     imm_b;
    rvcore_pkg::word_t     imm_j;
    logic [2:0]            f3;
    logic [6:0]            f7;
    logic                  exp_wen;
    rvcore_pkg::reg_addr_t exp_waddr;
    rvcore_pkg::word_t     exp_wdata;
    rvcore_pkg::word_t     exp_next;
    logic                  exp_unknown;
    logic                  is_ebreak;

    rv_core_top dut0 (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .inst         ( inst         ),
        .pc           ( pc           ),
        .reg_wen      ( reg_wen      ),
        .reg_waddr    ( reg_waddr    ),
        .reg_wdata    ( reg_wdata    ),
        .halted       ( halted       ),
        .unknown_code ( unknown_code )
    );

    function automatic rvcore_pkg::word_t r_type(input logic [6:0] fn7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] fn3, input logic [4:0] rd);
        return {fn7, rs2, rs1, fn3, rd, `OPC_OP};
    endfunction

    function automatic rvcore_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] fn3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, fn3, rd, opc};
    endfunction

    function automatic rvcore_pkg::word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
            input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic rvcore_pkg::word_t b_type(input logic [12:0] off, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] fn3);
        return {off[12], off[10:5], rs2, rs1, fn3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic rvcore_pkg::word_t j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
    endfunction

    // random legal register, immediate or lui instruction on x0..x15
    function automatic rvcore_pkg::word_t random_alu();
        logic [2:0]  fn3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic        alt;
        fn3 = 3'($urandom);
        rd  = 5'($urandom % 16);
        rs1 = 5'($urandom % 16);
        rs2 = 5'($urandom % 16);
        imm = 12'($urandom);
        alt = (fn3 == 3'd0 || fn3 == 3'd5) && ($urandom % 2 == 1);
        case ($urandom % 3)
            0: return r_type({1'b0, alt, 5'b0}, rs2, rs1, fn3, rd);
            1: begin
                if (fn3 == 3'd1) imm[11:5] = 7'b0;                  // slli shamt only
                if (fn3 == 3'd5) imm[11:5] = {1'b0, imm[10], 5'b0}; // srli or srai
                return i_type(imm, rs1, fn3, rd, `OPC_OP_IMM);
            end
            default: return u_type(20'($urandom), rd, `OPC_LUI);
        endcase
    endfunction

    function automatic rvcore_pkg::word_t fetch(input rvcore_pkg::word_t addr);
        rvcore_pkg::word_t idx;
        idx = (addr - `RESET_PC) >> 2;
        if (idx < PROG_LEN) return prog[idx[5:0]];
        return `INST_EBREAK; // running off the end halts
    endfunction

    function automatic rvcore_pkg::word_t alu_result(input logic [2:0] fn3, input logic alt,
            input rvcore_pkg::word_t a, input rvcore_pkg::word_t b);
        case (fn3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? rvcore_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] fn3, input rvcore_pkg::word_t a,
            input rvcore_pkg::word_t b);
        case (fn3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic append(input rvcore_pkg::word_t w);
        prog[n] = w;
        n = n + 6'd1;
    endtask

    // taken branch over a marker, then the same condition not taken
    task automatic branch_pair(input logic [2:0] fn3, input logic [4:0] t1, input logic [4:0] t2,
            input logic [4:0] n1, input logic [4:0] n2);
        append(b_type(13'd8, t2, t1, fn3));
        append(MARKER);
        append(b_type(13'd8, n2, n1, fn3));
    endtask

    task automatic mismatch(input string name, input rvcore_pkg::word_t expected,
            input rvcore_pkg::word_t actual);
        $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        $display("sim failed");
        $fatal(1);
    endtask

    initial begin
        forever #4 clk = ~clk; // 8 ns period
    end

    // one instruction per cycle, straight from the architectural rules
    always_comb begin
        m_inst      = fetch(m_pc);
        rs1v        = m_regs[m_inst[19:15]];
        rs2v        = m_regs[m_inst[24:20]];
        imm_i       = {{20{m_inst[31]}}, m_inst[31:20]};
        imm_b       = {{20{m_inst[31]}}, m_inst[7], m_inst[30:25], m_inst[11:8], 1'b0};
        imm_j       = {{12{m_inst[31]}}, m_inst[19:12], m_inst[20], m_inst[30:21], 1'b0};
        f3          = m_inst[14:12];
        f7          = m_inst[31:25];
        exp_waddr   = m_inst[11:7];
        exp_wen     = 1'b0;
        exp_wdata   = '0;
        exp_next    = m_pc + 32'd4;
        exp_unknown = 1'b0;
        is_ebreak   = 1'b0;
        case (m_inst[6:0])
            `OPC_OP: begin
                exp_unknown = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                exp_wen     = !exp_unknown;
                exp_wdata   = alu_result(f3, f7[5], rs1v, rs2v);
            end
            `OPC_OP_IMM: begin
                exp_unknown = (f3 == 3'd1 && f7 != 7'h00) ||
                              (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
                exp_wen     = !exp_unknown;
                exp_wdata   = alu_result(f3, f3 == 3'd5 && f7[5], rs1v, imm_i);
            end
            `OPC_LUI: begin
                exp_wen   = 1'b1;
                exp_wdata = {m_inst[31:12], 12'b0};
            end
            `OPC_AUIPC: begin
                exp_wen   = 1'b1;
                exp_wdata = m_pc + {m_inst[31:12], 12'b0};
            end
            `OPC_JAL: begin
                exp_wen   = 1'b1;
                exp_wdata = m_pc + 32'd4; // link
                exp_next  = m_pc + imm_j;
            end
            `OPC_JALR: begin
                exp_unknown = (f3 != 3'd0);
                exp_wen     = !exp_unknown;
                exp_wdata   = m_pc + 32'd4;
                if (!exp_unknown) exp_next = (rs1v + imm_i) & ~32'h1;
            end
            `OPC_BRANCH: begin
                exp_unknown = (f3 == 3'd2 || f3 == 3'd3);
                if (!exp_unknown && branch_taken(f3, rs1v, rs2v)) exp_next = m_pc + imm_b;
            end
            `OPC_SYSTEM: begin
                is_ebreak   = (m_inst == `INST_EBREAK);
                exp_unknown = !is_ebreak;
                if (is_ebreak) exp_next = m_pc;
            end
            default: exp_unknown = 1'b1;
        endcase
        if (m_halted) begin
            exp_wen  = 1'b0;
            exp_next = m_pc;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_pc     <= `RESET_PC;
            m_halted <= 1'b0;
            for (int i = 0; i < 32; i++) m_regs[i[4:0]] <= '0;
        end else if (!m_halted) begin
            m_pc <= exp_next;
            if (exp_wen && exp_waddr != 5'd0) m_regs[exp_waddr] <= exp_wdata;
            if (is_ebreak) m_halted <= 1'b1;
        end
    end

    assert property (@(posedge clk) !rst_n |-> pc == `RESET_PC)
        else mismatch("pc", `RESET_PC, $sampled(pc));
    assert property (@(posedge clk) !rst_n |-> !halted)
        else mismatch("halted", 32'd0, rvcore_pkg::word_t'($sampled(halted)));
    assert property (@(posedge clk) !rst_n |-> !reg_wen)
        else mismatch("reg_wen", 32'd0, rvcore_pkg::word_t'($sampled(reg_wen)));
    assert property (@(posedge clk) disable iff (!rst_n) pc == m_pc)
        else mismatch("pc", $sampled(m_pc), $sampled(pc));
    assert property (@(posedge clk) disable iff (!rst_n) halted == m_halted)
        else mismatch("halted", rvcore_pkg::word_t'($sampled(m_halted)),
                      rvcore_pkg::word_t'($sampled(halted)));
    assert property (@(posedge clk) disable iff (!rst_n) reg_wen == exp_wen)
        else mismatch("reg_wen", rvcore_pkg::word_t'($sampled(exp_wen)),
                      rvcore_pkg::word_t'($sampled(reg_wen)));
    assert property (@(posedge clk) disable iff (!rst_n) unknown_code == exp_unknown)
        else mismatch("unknown_code", rvcore_pkg::word_t'($sampled(exp_unknown)),
                      rvcore_pkg::word_t'($sampled(unknown_code)));
    assert property (@(posedge clk) disable iff (!rst_n) reg_wen |-> reg_waddr == exp_waddr)
        else mismatch("reg_waddr", rvcore_pkg::word_t'($sampled(exp_waddr)),
                      rvcore_pkg::word_t'($sampled(reg_waddr)));
    assert property (@(posedge clk) disable iff (!rst_n) reg_wen |-> reg_wdata == exp_wdata)
        else mismatch("reg_wdata", $sampled(exp_wdata), $sampled(reg_wdata));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: core did not halt within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $fatal(1);
        end
    end

    initial begin
        void'($urandom(2866));
        inst   = '0; // illegal, so reg_wen stays low in reset
        rst_n  = 1'b1;
        cycles = 0;
        n      = '0;
        for (int i = 0; i < PROG_LEN; i++) prog[i[5:0]] = `INST_EBREAK;
        append(u_type(20'h80000, 5'd1, `OPC_LUI));               // x1 = 0x80000000
        append(i_type(12'hffb, 5'd0, 3'd0, 5'd2, `OPC_OP_IMM));  // x2 = -5
        append(i_type(12'h007, 5'd0, 3'd0, 5'd3, `OPC_OP_IMM));  // x3 = 7
        append(u_type(20'h00001, 5'd4, `OPC_AUIPC));
        append(r_type(7'h20, 5'd3, 5'd2, 3'd5, 5'd5));           // sra
        append(r_type(7'h00, 5'd3, 5'd2, 3'd5, 5'd6));           // srl
        append(r_type(7'h00, 5'd3, 5'd2, 3'd2, 5'd7));           // slt
        append(r_type(7'h00, 5'd3, 5'd2, 3'd3, 5'd8));           // sltu
        append(i_type(12'h009, 5'd3, 3'd0, 5'd0, `OPC_OP_IMM));  // write to x0
        append(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));           // x9 = x0 + x0
        append(32'hffff_ffff);                                   // illegal
        append(r_type(7'h01, 5'd3, 5'd2, 3'd0, 5'd10));          // mul, outside rv32i
        append(i_type(12'h010, 5'd1, 3'd1, 5'd10, `OPC_JALR));   // jalr with a reserved funct3
        branch_pair(3'd0, 5'd3, 5'd3, 5'd2, 5'd3);
        branch_pair(3'd1, 5'd2, 5'd3, 5'd3, 5'd3);
        branch_pair(3'd4, 5'd2, 5'd3, 5'd3, 5'd2);
        branch_pair(3'd5, 5'd3, 5'd2, 5'd2, 5'd3);
        branch_pair(3'd6, 5'd3, 5'd2, 5'd2, 5'd3);
        branch_pair(3'd7, 5'd2, 5'd3, 5'd3, 5'd2);
        append(j_type(21'd8, 5'd11));
        append(MARKER);
        append(u_type(20'h0, 5'd13, `OPC_AUIPC));
        append(i_type(12'd13, 5'd13, 3'd0, 5'd12, `OPC_JALR));  // odd target, bit 0 dropped
        append(MARKER);
        for (int k = 0; k < N_RAND; k++) append(random_alu());
        @(negedge clk);
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        forever begin
            inst = fetch(pc);
            @(negedge clk);
        end
    end

    initial begin
        wait (m_halted);
        repeat (6) @(negedge clk); // five halted cycles checked
        $display("sim passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+src
src/rvcore_pkg.sv
src/pc_unit.sv
src/decoder.sv
src/imm_gen.sv
src/reg_file.sv
src/alu.sv
src/rv_core_top.sv
test/tb_rv_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_rv_core -f sim.f &&
./obj_dir/Vtb_rv_core | grep "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }
